//--- include/rtc_config.svh
`ifndef RTC_CONFIG_SVH
`define RTC_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus timing
//////////////////////////////////////////////////////////////////////

// Clock cycles spent in each of Address, Strobe and Recover
`define BUS_PHASE 2

// Idle cycles between two register sweeps
`define WAIT_TICKS 16

//////////////////////////////////////////////////////////////////////
// Chip register map
//////////////////////////////////////////////////////////////////////

`define ADDR_LO_FIRST 8'h21 // Seconds
`define ADDR_LO_LAST  8'h26 // End of time block
`define ADDR_HI_FIRST 8'h41 // Start of date block
`define ADDR_HI_LAST  8'h43 // Year

// Transfer command, written once per sweep
`define CMD_ADDR 8'hF0

// Registers held in the shadow bank
`define NUM_REGS 9

`endif

//--- hw/rtcPkg.sv
package rtcPkg;

	// Address phase byte on the multiplexed bus
	typedef logic [7:0] rtcAddr;

	// One chip register
	typedef logic [7:0] rtcData;

	// Edit cursor, low seven bits of a time register address
	typedef logic [6:0] cursorPtr;

	// Main sequencer of the menu controller
	typedef enum logic [2:0]
	{
		SwIdle,    // Out of reset
		SwSweep,   // Register transactions
		SwCommand, // Write to command register
		SwWait,    // Pause between sweeps
		SwDecide   // Pick read or write for next sweep
	} sweepState;

	// Phases of one bus transaction
	typedef enum logic [1:0]
	{
		BpIdle,
		BpAddress, // ALE high, address on AD
		BpStrobe,  // RD or WR low
		BpRecover  // All strobes released
	} busPhase;

endpackage

//--- hw/buttonSync.sv
`timescale 1ns/1ps

module buttonSync
(
	input  logic CLK,
	input  logic RST,
	input  logic btnUp,
	input  logic btnDown,
	input  logic btnLeft,
	input  logic btnRight,
	input  logic btnCenter,
	input  logic alarmStop,
	input  logic irq,
	output logic upP,
	output logic downP,
	output logic leftP,
	output logic rightP,
	output logic centerP,
	output logic stopP,
	output logic irqP
);

	localparam int NumIn = 7;

	logic [NumIn-1:0] rawIn;   // Asynchronous pins
	logic [NumIn-1:0] syncA;   // First metastability stage
	logic [NumIn-1:0] syncB;   // Settled level
	logic [NumIn-1:0] prevB;   // Level one cycle earlier
	logic [NumIn-1:0] pulse;

	assign rawIn = {irq, alarmStop, btnCenter, btnRight, btnLeft, btnDown, btnUp};

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			syncA <= '0;
			syncB <= '0;
			prevB <= '0;
		end
		else
		begin
			syncA <= rawIn;
			syncB <= syncA;
			prevB <= syncB;
		end
	end

	// Rising edge only, one cycle wide
	assign pulse = syncB & ~prevB;

	assign {irqP, stopP, centerP, rightP, leftP, downP, upP} = pulse;

	// A held button must not repeat its pulse
	assert property (@(posedge CLK) disable iff (RST) (pulse & $past(pulse)) == '0);

endmodule

//--- hw/menuControl.sv
`timescale 1ns/1ps

`include "rtc_config.svh"

module menuControl
	import rtcPkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     upP,
	input  logic     downP,
	input  logic     leftP,
	input  logic     rightP,
	input  logic     centerP,
	input  logic     stopP,
	input  logic     irqP,
	input  logic     busy,
	input  logic     done,
	output logic     access,
	output logic     wrEn,
	output logic     modWrite,
	output logic     numUp,
	output logic     numDown,
	output logic     alarm,
	output logic     stopWrite,
	output rtcAddr   addr,
	output cursorPtr cursor
);

	localparam rtcAddr LoFirst = `ADDR_LO_FIRST;
	localparam rtcAddr LoLast  = `ADDR_LO_LAST;
	localparam rtcAddr HiFirst = `ADDR_HI_FIRST;
	localparam rtcAddr HiLast  = `ADDR_HI_LAST;
	localparam rtcAddr CmdAddr = `CMD_ADDR;

	localparam cursorPtr CurLoFirst = cursorPtr'(`ADDR_LO_FIRST);
	localparam cursorPtr CurLoLast  = cursorPtr'(`ADDR_LO_LAST);
	localparam cursorPtr CurHiFirst = cursorPtr'(`ADDR_HI_FIRST);
	localparam cursorPtr CurHiLast  = cursorPtr'(`ADDR_HI_LAST);

	localparam int WaitW = ($clog2(`WAIT_TICKS) > 0) ? $clog2(`WAIT_TICKS) : 1;
	localparam logic [WaitW-1:0] WaitLast = WaitW'(`WAIT_TICKS - 1);

	sweepState        state;
	logic [WaitW-1:0] waitCnt;
	logic             centerReq; // Write sweep requested since last Decide
	rtcAddr           addrNext;
	cursorPtr         cursorNext;

	//////////////////////////////////////////////////////////////////////
	// Sweep sequencer
	//////////////////////////////////////////////////////////////////////

	// Time block runs straight into the date block
	assign addrNext = (addr == LoLast) ? HiFirst : addr + 8'd1;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state     <= SwIdle;
			access    <= 1'b0;
			wrEn      <= 1'b0;
			addr      <= LoFirst;
			modWrite  <= 1'b0; // First sweep reads
			centerReq <= 1'b0;
			waitCnt   <= '0;
		end
		else
		begin
			access <= 1'b0; // Strobe is a single cycle
			if (centerP)
				centerReq <= 1'b1;
			case (state)
				SwIdle:
				begin
					if (!busy)
					begin
						state  <= SwSweep;
						addr   <= LoFirst;
						wrEn   <= modWrite;
						access <= 1'b1;
					end
				end
				SwSweep:
				begin
					if (done)
					begin
						access <= 1'b1; // Next transaction one cycle after done
						if (addr == HiLast)
						begin
							state <= SwCommand;
							addr  <= CmdAddr;
							wrEn  <= 1'b1; // Command is always a write
						end
						else
							addr <= addrNext;
					end
				end
				SwCommand:
				begin
					if (done)
					begin
						state   <= SwWait;
						wrEn    <= 1'b0;
						waitCnt <= '0;
					end
				end
				SwWait:
				begin
					if (waitCnt == WaitLast)
						state <= SwDecide;
					else
						waitCnt <= waitCnt + 1'b1;
				end
				SwDecide:
				begin
					if (!busy)
					begin
						modWrite  <= centerReq | centerP; // Latched or arriving now
						wrEn      <= centerReq | centerP;
						centerReq <= 1'b0;
						addr      <= LoFirst;
						access    <= 1'b1;
						state     <= SwSweep;
					end
				end
				default: state <= SwIdle;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Cursor, edit pulses and alarm
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cursorNext = cursor;
		if (centerP)
			cursorNext = CurLoFirst; // Center homes the cursor
		else if (leftP && !rightP)
		begin
			case (cursor)
				CurLoLast: cursorNext = CurHiFirst;
				CurHiLast: cursorNext = CurLoFirst;
				default:   cursorNext = cursor + 7'd1;
			endcase
		end
		else if (rightP && !leftP)
		begin
			case (cursor)
				CurLoFirst: cursorNext = CurHiLast;
				CurHiFirst: cursorNext = CurLoLast;
				default:    cursorNext = cursor - 7'd1;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			cursor    <= CurLoFirst;
			numUp     <= 1'b0;
			numDown   <= 1'b0;
			alarm     <= 1'b0;
			stopWrite <= 1'b0;
		end
		else
		begin
			cursor    <= cursorNext;
			numUp     <= upP;
			numDown   <= downP;
			stopWrite <= stopP & ~irqP; // Only when the alarm really clears
			if (irqP)
				alarm <= 1'b1; // Interrupt beats the stop key
			else if (stopP)
				alarm <= 1'b0;
		end
	end

	// Bus master must be free for every strobe
	assert property (@(posedge CLK) disable iff (RST) access |-> !busy);

	// Cursor only visits the two register blocks
	assert property (@(posedge CLK) disable iff (RST)
		(cursor >= CurLoFirst && cursor <= CurLoLast) ||
		(cursor >= CurHiFirst && cursor <= CurHiLast));

endmodule

//--- hw/timeShadow.sv
`timescale 1ns/1ps

`include "rtc_config.svh"

module timeShadow
	import rtcPkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     done,
	input  logic     modWrite,
	input  logic     numUp,
	input  logic     numDown,
	input  rtcAddr   addr,
	input  rtcData   rdData,
	input  cursorPtr cursor,
	output rtcData   wrData,
	output rtcData   editValue,
	output logic     pending
);

	localparam int IdxW  = $clog2(`NUM_REGS);
	localparam int LoCnt = `ADDR_LO_LAST - `ADDR_LO_FIRST + 1; // Slots before date block

	rtcData          regs [`NUM_REGS]; // One byte per swept register
	logic [IdxW-1:0] sweepIdx;
	logic [IdxW-1:0] editIdx;
	logic            sweepHit;  // Sweep address is a time register
	logic            storeRead;
	logic            cmdDone;

	function automatic logic [IdxW-1:0] slotOf(input rtcAddr a);
		if (a <= `ADDR_LO_LAST)
			return IdxW'(a - `ADDR_LO_FIRST);
		return IdxW'(a - `ADDR_HI_FIRST + LoCnt);
	endfunction

	assign sweepIdx = slotOf(addr);
	assign editIdx  = slotOf({1'b0, cursor});
	assign sweepHit = (addr >= `ADDR_LO_FIRST && addr <= `ADDR_LO_LAST) ||
		(addr >= `ADDR_HI_FIRST && addr <= `ADDR_HI_LAST);

	assign storeRead = done && !modWrite && !pending && sweepHit;
	assign cmdDone   = done && modWrite && (addr == `CMD_ADDR); // End of write sweep

	// Command byte tells the chip which way the RAM copy goes
	assign wrData    = (addr == `CMD_ADDR) ? {7'd0, modWrite} : regs[sweepIdx];
	assign editValue = regs[editIdx];

	always_ff @(posedge CLK)
	begin
		if (storeRead)
			regs[sweepIdx] <= rdData;
		if (numUp)
			regs[editIdx] <= regs[editIdx] + 8'd1; // Plain byte wrap
		else if (numDown)
			regs[editIdx] <= regs[editIdx] - 8'd1;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			pending <= 1'b0;
		else if (numUp || numDown)
			pending <= 1'b1; // Fresh edit outranks the clear
		else if (cmdDone)
			pending <= 1'b0;
	end

endmodule

//--- hw/rtcBusMaster.sv
`timescale 1ns/1ps

`include "rtc_config.svh"

module rtcBusMaster
	import rtcPkg::*;
(
	input  logic   CLK,
	input  logic   RST,
	input  logic   access,
	input  logic   wrEn,
	input  rtcAddr addr,
	input  rtcData wrData,
	input  rtcData adIn,
	output logic   busy,
	output logic   done,
	output logic   ale,
	output logic   csN,
	output logic   rdN,
	output logic   wrN,
	output logic   adOe,
	output rtcData adOut,
	output rtcData rdData
);

	localparam int CntW = ($clog2(`BUS_PHASE) > 0) ? $clog2(`BUS_PHASE) : 1;
	localparam logic [CntW-1:0] PhaseLast = CntW'(`BUS_PHASE - 1);

	busPhase         phase;
	logic [CntW-1:0] phaseCnt;
	logic            phaseEnd; // Last cycle of current phase
	logic            wrLatch;  // Transaction is a write
	rtcAddr          addrLatch;
	rtcData          dataLatch;

	assign phaseEnd = (phaseCnt == PhaseLast);

	//////////////////////////////////////////////////////////////////////
	// Phase sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			phase    <= BpIdle;
			phaseCnt <= '0;
			wrLatch  <= 1'b0;
		end
		else
		begin
			if (phase != BpIdle)
				phaseCnt <= phaseEnd ? '0 : phaseCnt + 1'b1;
			case (phase)
				BpIdle:
				begin
					if (access)
					begin
						phase    <= BpAddress;
						phaseCnt <= '0;
						wrLatch  <= wrEn;
					end
				end
				BpAddress: if (phaseEnd) phase <= BpStrobe;
				BpStrobe:  if (phaseEnd) phase <= BpRecover;
				BpRecover: if (phaseEnd) phase <= BpIdle;
				default:   phase <= BpIdle;
			endcase
		end
	end

	// Address and data held for the whole transaction
	always_ff @(posedge CLK)
	begin
		if (phase == BpIdle && access)
		begin
			addrLatch <= addr;
			dataLatch <= wrData;
		end
		if (phase == BpStrobe && phaseEnd && !wrLatch)
			rdData <= adIn; // Sample just before RD rises
	end

	//////////////////////////////////////////////////////////////////////
	// Pin decode
	//////////////////////////////////////////////////////////////////////

	assign busy  = (phase != BpIdle);
	assign done  = (phase == BpRecover) && phaseEnd;
	assign ale   = (phase == BpAddress);
	assign csN   = !(phase == BpAddress || phase == BpStrobe);
	assign rdN   = !(phase == BpStrobe && !wrLatch);
	assign wrN   = !(phase == BpStrobe && wrLatch);
	assign adOe  = (phase == BpAddress) || (phase == BpStrobe && wrLatch);
	assign adOut = (phase == BpAddress) ? addrLatch : dataLatch;

	// Never both strobes
	assert property (@(posedge CLK) disable iff (RST) !(!rdN && !wrN));

	// Slave owns AD while it is being read
	assert property (@(posedge CLK) disable iff (RST) !rdN |-> !adOe);

	// Fixed transaction length
	assert property (@(posedge CLK) disable iff (RST)
		(access && !busy) |-> ##(3 * `BUS_PHASE) done);

endmodule

//--- hw/rtcMenuTop.sv
`timescale 1ns/1ps

module rtcMenuTop
	import rtcPkg::*;
(
	input  logic     CLK,
	input  logic     RST,
	input  logic     btnUp,
	input  logic     btnDown,
	input  logic     btnLeft,
	input  logic     btnRight,
	input  logic     btnCenter,
	input  logic     alarmStop,
	input  logic     irq,
	input  rtcData   adIn,
	output logic     ale,
	output logic     csN,
	output logic     rdN,
	output logic     wrN,
	output logic     adOe,
	output logic     alarm,
	output logic     stopWrite,
	output logic     pending,
	output rtcData   adOut,
	output rtcData   editValue,
	output cursorPtr cursor
);

	logic   upP, downP, leftP, rightP, centerP, stopP, irqP; // Clean pulses
	logic   access, wrEn, busy, done;                       // Bus request side
	logic   modWrite, numUp, numDown;                       // Shadow control
	rtcAddr addr;
	rtcData wrData;
	rtcData rdData;

	buttonSync i_buttonSync (
		.CLK, .RST, .btnUp, .btnDown, .btnLeft, .btnRight, .btnCenter, .alarmStop, .irq,
		.upP, .downP, .leftP, .rightP, .centerP, .stopP, .irqP
	);

	menuControl i_menuControl (
		.CLK, .RST, .upP, .downP, .leftP, .rightP, .centerP, .stopP, .irqP, .busy, .done,
		.access, .wrEn, .modWrite, .numUp, .numDown, .alarm, .stopWrite, .addr, .cursor
	);

	timeShadow i_timeShadow (
		.CLK, .RST, .done, .modWrite, .numUp, .numDown, .addr, .rdData, .cursor,
		.wrData, .editValue, .pending
	);

	rtcBusMaster i_rtcBusMaster (
		.CLK, .RST, .access, .wrEn, .addr, .wrData, .adIn,
		.busy, .done, .ale, .csN, .rdN, .wrN, .adOe, .adOut, .rdData
	);

endmodule

//--- testbench/rtcModel.sv
`timescale 1ns/1ps

`include "rtc_config.svh"

module rtcModel
	import rtcPkg::*;
(
	input  logic   CLK,
	input  logic   ale,
	input  logic   csN,
	input  logic   rdN,
	input  logic   wrN,
	input  rtcData adOut, // AD pins as driven by the DUT
	output rtcData adIn   // Read data back to the DUT
);

	localparam int LogDepth = 1024;

	rtcData      regs [`NUM_REGS];     // Chip time and date registers
	rtcAddr      curAddr = '0;         // Latched during ALE
	logic        rdPrev  = 1'b1;
	logic        wrPrev  = 1'b1;
	logic [31:0] rng;
	int          curSlot;

	// Transaction log in bus order
	rtcAddr logAddr [LogDepth];
	rtcData logData [LogDepth];
	logic   logWr   [LogDepth];
	int     logCount = 0;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Slot in the register array, -1 outside both blocks
	function automatic int slotIndex(input rtcAddr a);
		if (a >= `ADDR_LO_FIRST && a <= `ADDR_LO_LAST)
			return int'(a - `ADDR_LO_FIRST);
		if (a >= `ADDR_HI_FIRST && a <= `ADDR_HI_LAST)
			return int'(a - `ADDR_HI_FIRST) + (`ADDR_LO_LAST - `ADDR_LO_FIRST + 1);
		return -1;
	endfunction

	initial
	begin
		rng = 32'd93250; // Fixed seed
		for (int i = 0; i < `NUM_REGS; i++)
		begin
			rng     = xorshift(rng);
			regs[i] = rng[7:0];
		end
	end

	assign curSlot = slotIndex(curAddr);
	assign adIn    = (!rdN && !csN && curSlot >= 0) ? regs[curSlot] : 8'hFF; // Bus floats high

	always @(posedge CLK)
	begin
		rdPrev <= rdN;
		wrPrev <= wrN;
		if (ale && !csN)
			curAddr <= adOut;
		// One log entry at the start of each strobe
		if (!csN && logCount < LogDepth && ((!rdN && rdPrev) || (!wrN && wrPrev)))
		begin
			logAddr[logCount] <= curAddr;
			logWr[logCount]   <= !wrN;
			logData[logCount] <= !wrN ? adOut : adIn;
			logCount          <= logCount + 1;
		end
		if (!wrN && wrPrev && !csN && curSlot >= 0)
			regs[curSlot] <= adOut; // Command register is not stored
	end

endmodule

//--- testbench/tbRtcMenu.sv
`timescale 1ns/1ps

`include "rtc_config.svh"

module tbRtcMenu
	import rtcPkg::*;
();

	localparam int NumTests      = 6;
	localparam int TimeoutCycles = NumTests * (10 * 3 * `BUS_PHASE + `WAIT_TICKS + 40) * 4;

	// Key order {irq, alarmStop, center, right, left, down, up}
	localparam logic [6:0] KeyUp     = 7'h01;
	localparam logic [6:0] KeyDown   = 7'h02;
	localparam logic [6:0] KeyLeft   = 7'h04;
	localparam logic [6:0] KeyRight  = 7'h08;
	localparam logic [6:0] KeyCenter = 7'h10;
	localparam logic [6:0] KeyStop   = 7'h20;
	localparam logic [6:0] KeyIrq    = 7'h40;

	// Cursor walk through every wrap point, then home
	localparam logic [6:0] CursorKeys [10] = '{KeyRight, KeyRight, KeyRight, KeyRight, KeyLeft,
		KeyLeft, KeyLeft, KeyLeft, KeyLeft, KeyCenter};
	localparam logic [7:0] CursorSteps [10] = '{8'h43, 8'h42, 8'h41, 8'h26, 8'h41,
		8'h42, 8'h43, 8'h21, 8'h22, 8'h21};
	localparam logic [6:0] EditKeys [3] = '{KeyUp, KeyUp, KeyDown};

	logic     CLK, RST;
	logic     btnUp, btnDown, btnLeft, btnRight, btnCenter, alarmStop, irq;
	logic     ale, csN, rdN, wrN, adOe, alarm, stopWrite, pending;
	rtcData   adIn, adOut, editValue;
	cursorPtr cursor;

	int     errCount = 0;
	int     protoErrCount = 0;  // Bus rule breaks seen by the monitor
	int     stopCount = 0;      // stopWrite pulses so far
	int     testsRun = 0;
	int     testsFailed = 0;
	int     scanPos = 0;        // Next model log entry to inspect
	int     cycleCount = 0;
	int     lowRun = 0;         // Current csN low stretch
	rtcData editExpect;         // Edited byte at 0x21
	string  testName;

	rtcMenuTop i_dut (
		.CLK, .RST, .btnUp, .btnDown, .btnLeft, .btnRight, .btnCenter, .alarmStop, .irq,
		.adIn, .ale, .csN, .rdN, .wrN, .adOe, .alarm, .stopWrite, .pending,
		.adOut, .editValue, .cursor
	);

	rtcModel i_model (.CLK, .ale, .csN, .rdN, .wrN, .adOut, .adIn);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Address of the i-th register in sweep order
	function automatic rtcAddr sweepAddr(input int i);
		if (i < `ADDR_LO_LAST - `ADDR_LO_FIRST + 1)
			return rtcAddr'(`ADDR_LO_FIRST + i);
		return rtcAddr'(`ADDR_HI_FIRST + i - (`ADDR_LO_LAST - `ADDR_LO_FIRST + 1));
	endfunction

	task automatic setKeys(input logic [6:0] keys);
		{irq, alarmStop, btnCenter, btnRight, btnLeft, btnDown, btnUp} = keys;
	endtask

	// Five cycles high, then time for the three-cycle pipeline to settle
	task automatic pressKeys(input logic [6:0] keys);
		@(negedge CLK);
		setKeys(keys);
		repeat (5) @(negedge CLK);
		setKeys('0);
		repeat (4) @(negedge CLK);
	endtask

	task automatic checkValue(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (actual === expected)
		else
		begin
			$display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
			errCount++;
		end
	endtask

	// Scan the model log for a command write carrying cmdData
	task automatic waitCommand(input rtcData cmdData, output int cmdIdx);
		cmdIdx = -1;
		while (cmdIdx < 0)
		begin
			@(negedge CLK);
			while (cmdIdx < 0 && scanPos < i_model.logCount)
			begin
				if (i_model.logWr[scanPos] && i_model.logAddr[scanPos] == `CMD_ADDR &&
					i_model.logData[scanPos] == cmdData)
					cmdIdx = scanPos;
				scanPos++;
			end
		end
	endtask

	task automatic reportTest(input int errBefore);
		testsRun++;
		if (errCount == errBefore)
			$display("test %s: passed", testName);
		else
		begin
			testsFailed++;
			$display("test %s: failed with %0d errors", testName, errCount - errBefore);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic readSweepTest();
		int errBefore, cmdIdx, i;
		errBefore = errCount;
		testName  = "readSweep";
		waitCommand(8'h00, cmdIdx);
		checkValue("command position", 8'(`NUM_REGS), 8'(cmdIdx)); // Nine reads come first
		for (i = 0; i < `NUM_REGS; i++)
		begin
			checkValue($sformatf("addr %0d", i), sweepAddr(i), i_model.logAddr[i]);
			checkValue($sformatf("write flag %0d", i), 8'd0, {7'd0, i_model.logWr[i]});
		end
		checkValue("cursor", 8'h21, {1'b0, cursor});
		checkValue("editValue", i_model.regs[0], editValue);
		checkValue("pending", 8'd0, {7'd0, pending});
		reportTest(errBefore);
	endtask

	task automatic cursorTest();
		int errBefore, i;
		errBefore = errCount;
		testName  = "cursor";
		for (i = 0; i < 10; i++)
		begin
			pressKeys(CursorKeys[i]);
			checkValue($sformatf("step %0d", i), CursorSteps[i], {1'b0, cursor});
		end
		reportTest(errBefore);
	endtask

	task automatic editTest();
		int errBefore, cmdIdx, i;
		rtcData expected;
		errBefore = errCount;
		testName  = "edit";
		waitCommand(8'h01, cmdIdx); // Write sweep from the center press
		expected = i_model.regs[0]; // Chip byte at 0x21 before any edit
		for (i = 0; i < 3; i++)
		begin
			pressKeys(EditKeys[i]);
			expected = (EditKeys[i] == KeyUp) ? expected + 8'd1 : expected - 8'd1;
			checkValue($sformatf("value %0d", i), expected, editValue);
			checkValue($sformatf("pending %0d", i), 8'd1, {7'd0, pending});
		end
		editExpect = expected;
		waitCommand(8'h00, cmdIdx);
		waitCommand(8'h00, cmdIdx); // One full read sweep after the edits
		checkValue("value after read sweep", editExpect, editValue);
		checkValue("pending after read sweep", 8'd1, {7'd0, pending});
		reportTest(errBefore);
	endtask

	task automatic writeSweepTest();
		int errBefore, cmdIdx, i, k;
		rtcData expected [`NUM_REGS];
		errBefore = errCount;
		testName  = "writeSweep";
		for (i = 0; i < `NUM_REGS; i++)
			expected[i] = i_model.regs[i];
		expected[0] = editExpect; // Cursor sits on 0x21
		pressKeys(KeyCenter);
		waitCommand(8'h01, cmdIdx);
		for (i = 0; i < `NUM_REGS; i++)
		begin
			k = cmdIdx - `NUM_REGS + i;
			checkValue($sformatf("addr %0d", i), sweepAddr(i), i_model.logAddr[k]);
			checkValue($sformatf("write flag %0d", i), 8'd1, {7'd0, i_model.logWr[k]});
			checkValue($sformatf("data %0d", i), expected[i], i_model.logData[k]);
		end
		i = 0;
		while (pending && i < 4 * `BUS_PHASE) // Clears at the command done
		begin
			@(negedge CLK);
			i++;
		end
		checkValue("pending", 8'd0, {7'd0, pending});
		checkValue("model byte", editExpect, i_model.regs[0]);
		reportTest(errBefore);
	endtask

	task automatic alarmTest();
		int errBefore, stopBefore;
		errBefore = errCount;
		testName  = "alarm";
		checkValue("alarm idle", 8'd0, {7'd0, alarm});
		pressKeys(KeyIrq);
		checkValue("alarm set", 8'd1, {7'd0, alarm});
		stopBefore = stopCount;
		pressKeys(KeyStop);
		checkValue("alarm cleared", 8'd0, {7'd0, alarm});
		checkValue("stopWrite pulses", 8'd1, 8'(stopCount - stopBefore));
		pressKeys(KeyIrq);
		stopBefore = stopCount;
		pressKeys(KeyIrq | KeyStop); // Interrupt wins
		checkValue("alarm held", 8'd1, {7'd0, alarm});
		checkValue("stopWrite pulses on tie", 8'd0, 8'(stopCount - stopBefore));
		reportTest(errBefore);
	endtask

	task automatic busProtocolTest();
		int errBefore;
		errBefore = errCount;
		testName  = "busProtocol";
		assert (protoErrCount == 0)
		else
		begin
			$display("bus protocol was broken %0d times during the run", protoErrCount);
			errCount++;
		end
		assert (i_model.logCount > 0)
		else
		begin
			$display("no bus transaction reached the chip model");
			errCount++;
		end
		reportTest(errBefore);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus monitor, stimulus and timeout
	//////////////////////////////////////////////////////////////////////

	always @(negedge CLK)
	begin
		if (!RST)
		begin
			if (stopWrite)
				stopCount++;
			assert (rdN || wrN)
			else
			begin
				$display("read and write strobes low together at cycle %0d", cycleCount);
				protoErrCount++;
			end
			assert (!csN || (rdN && wrN && !ale))
			else
			begin
				$display("strobe or ALE active without chip select at cycle %0d", cycleCount);
				protoErrCount++;
			end
			// AD belongs to the chip while it reads and while it is deselected
			assert (!adOe || (!csN && rdN))
			else
			begin
				$display("DUT drives AD outside address or write phase at cycle %0d", cycleCount);
				protoErrCount++;
			end
			assert (adOe || (!ale && wrN))
			else
			begin
				$display("DUT leaves AD undriven during ALE or write strobe at cycle %0d",
					cycleCount);
				protoErrCount++;
			end
			if (!csN)
				lowRun++;
			else
			begin
				// Chip select must rise after every Address and Strobe pair
				if (lowRun != 0)
					assert (lowRun == 2 * `BUS_PHASE)
					else
					begin
						$display("ERR busProtocol csN low cycles: expected %0d, actual %0d",
							2 * `BUS_PHASE, lowRun);
						protoErrCount++;
					end
				lowRun = 0;
			end
		end
	end

	initial
	begin
		RST = 1'b1;
		setKeys('0);
		repeat (4) @(negedge CLK);
		RST = 1'b0;
		readSweepTest();
		cursorTest();
		editTest();
		writeSweepTest();
		alarmTest();
		busProtocolTest();
		$display("summary: %0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout after %0d cycles, tests did not complete", cycleCount);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- project.f
+incdir+include
hw/rtcPkg.sv
hw/buttonSync.sv
hw/menuControl.sv
hw/timeShadow.sv
hw/rtcBusMaster.sv
hw/rtcMenuTop.sv
testbench/rtcModel.sv
testbench/tbRtcMenu.sv

//--- run.sh
#!/bin/sh
# Build and run the RTC menu testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tbRtcMenu -o simRtcMenu

./obj_dir/simRtcMenu > sim.log 2>&1
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
